//--- axi_mem_pkg.sv
package axi_mem_pkg;

   localparam int data_bytes = 4;                      // bytes per beat and number of banks
   localparam int mem_bytes  = 128;
   localparam int mem_words  = mem_bytes / data_bytes; // entries per bank
   localparam int idx_w      = 5;

   localparam logic [1:0] burst_fixed = 2'd0;
   localparam logic [1:0] burst_incr  = 2'd1;
   localparam logic [1:0] burst_wrap  = 2'd2;

   localparam logic [1:0] resp_okay   = 2'd0;
   localparam logic [1:0] resp_slverr = 2'd2;
   localparam logic [1:0] resp_decerr = 2'd3;

   localparam logic [2:0] full_size = 3'd2; // 4 bytes per beat

   // shared by aw and ar
   typedef struct packed {
      logic [3:0]  id;
      logic [31:0] addr;
      logic [3:0]  len;
      logic [2:0]  size;
      logic [1:0]  burst;
   } addr_req_t;

   typedef struct packed {
      logic [31:0] data;
      logic [3:0]  strb;
      logic        last;
   } w_beat_t;

   typedef struct packed {
      logic [3:0] id;
      logic [1:0] resp;
   } b_resp_t;

   typedef struct packed {
      logic [3:0]  id;
      logic [31:0] data;
      logic [1:0]  resp;
      logic        last;
   } r_beat_t;

   // word index of the following beat
   function automatic logic [idx_w-1:0] next_index(input logic [idx_w-1:0] idx,
                                                   input logic [3:0]       len,
                                                   input logic [1:0]       burst);
      logic [idx_w-1:0] mask;
      logic [idx_w-1:0] step;
      mask = idx_w'(len); // len is 2^n-1 for legal wraps
      step = idx + 1'b1;
      case (burst)
         burst_incr: return step;
         burst_wrap: return (idx & ~mask) | (step & mask); // roll inside window
         default:    return idx;                           // fixed
      endcase
   endfunction

   function automatic logic [1:0] check_req(input addr_req_t req);
      if (req.size != full_size) begin
         return resp_slverr;
      end
      if (req.burst == 2'd3) begin
         return resp_slverr; // reserved code
      end
      if (req.burst == burst_wrap && !(req.len inside {4'd1, 4'd3, 4'd7, 4'd15})) begin
         return resp_slverr;
      end
      if (req.addr >= 32'(mem_bytes)) begin
         return resp_decerr;
      end
      return resp_okay;
   endfunction

endpackage

//--- byte_lane_bank.sv
`timescale 1ns/1ps

// one byte lane of the word memory
module byte_lane_bank (
   input  logic                          clk,
   input  logic                          wr_en,
   input  logic [axi_mem_pkg::idx_w-1:0] wr_index,
   input  logic [7:0]                    wr_byte,
   input  logic                          rd_en,
   input  logic [axi_mem_pkg::idx_w-1:0] rd_index,
   output logic [7:0]                    rd_byte
);

   logic [7:0] mem [axi_mem_pkg::mem_words];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_index] <= wr_byte;
      end
   end

   // read port holds its last byte when idle
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_byte <= mem[rd_index];
      end
   end

endmodule

//--- axi_write_ctrl.sv
`timescale 1ns/1ps

module axi_write_ctrl (
   input  logic                          clk,
   input  logic                          resetn,
   input  logic                          aw_valid,
   input  axi_mem_pkg::addr_req_t        aw,
   output logic                          aw_ready,
   input  logic                          w_valid,
   input  axi_mem_pkg::w_beat_t          w,
   output logic                          w_ready,
   input  logic                          b_ready,
   output logic                          b_valid,
   output axi_mem_pkg::b_resp_t          b,
   output logic [3:0]                    lane_we,
   output logic [axi_mem_pkg::idx_w-1:0] wr_index,
   output logic [31:0]                   wr_data
);

   typedef enum logic [1:0] {
      st_addr,
      st_data,
      st_resp
   } state_t;

   state_t state;

   logic [3:0]                    req_id;
   logic [3:0]                    req_len;
   logic [1:0]                    req_burst;
   logic [1:0]                    req_resp; // check result echoed on b
   logic [axi_mem_pkg::idx_w-1:0] idx;
   logic                          aw_fire;
   logic                          w_fire;
   logic                          b_fire;

   assign aw_fire = aw_valid && aw_ready;
   assign w_fire  = w_valid && w_ready;
   assign b_fire  = b_valid && b_ready;

   always_ff @(posedge clk or negedge resetn) begin
      if (!resetn) begin
         state    <= st_addr;
         aw_ready <= 1'b0;
         w_ready  <= 1'b0;
         b_valid  <= 1'b0;
         lane_we  <= '0;
      end else begin
         lane_we <= '0; // single cycle write pulse
         case (state)
            st_addr: begin
               aw_ready <= 1'b1;
               if (aw_fire) begin
                  aw_ready <= 1'b0;
                  w_ready  <= 1'b1;
                  state    <= st_data;
               end
            end
            st_data: begin
               if (w_fire) begin
                  if (req_resp == axi_mem_pkg::resp_okay) begin
                     lane_we <= w.strb;
                  end
                  // last ends the burst whatever the beat count
                  if (w.last) begin
                     w_ready <= 1'b0;
                     b_valid <= 1'b1;
                     state   <= st_resp;
                  end
               end
            end
            st_resp: begin
               if (b_fire) begin
                  b_valid  <= 1'b0;
                  aw_ready <= 1'b1;
                  state    <= st_addr;
               end
            end
            default: state <= st_addr;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (aw_fire) begin
         req_id    <= aw.id;
         req_len   <= aw.len;
         req_burst <= aw.burst;
         req_resp  <= axi_mem_pkg::check_req(aw);
         idx       <= aw.addr[2 +: axi_mem_pkg::idx_w]; // byte offset dropped
      end
      if (w_fire) begin
         wr_index <= idx;
         wr_data  <= w.data;
         idx      <= axi_mem_pkg::next_index(idx, req_len, req_burst);
      end
   end

   assign b = '{id: req_id, resp: req_resp};

   a_b_hold: assert property (@(posedge clk) disable iff (!resetn)
      b_valid && !b_ready |=> b_valid)
      else $error("b_valid dropped before b_ready");

   a_ready_excl: assert property (@(posedge clk) disable iff (!resetn)
      !(aw_ready && w_ready))
      else $error("aw_ready and w_ready both high");

endmodule

//--- axi_read_ctrl.sv
`timescale 1ns/1ps

module axi_read_ctrl (
   input  logic                          clk,
   input  logic                          resetn,
   input  logic                          ar_valid,
   input  axi_mem_pkg::addr_req_t        ar,
   output logic                          ar_ready,
   input  logic                          r_ready,
   output logic                          r_valid,
   output axi_mem_pkg::r_beat_t          r,
   output logic                          rd_en,
   output logic [axi_mem_pkg::idx_w-1:0] rd_index,
   input  logic [31:0]                   rd_word
);

   typedef enum logic [1:0] {
      st_addr,
      st_issue,   // bank read in flight
      st_wait,    // bank data valid
      st_present  // beat on r
   } state_t;

   state_t state;

   logic [3:0]                    req_id;
   logic [3:0]                    req_len;
   logic [1:0]                    req_burst;
   logic [1:0]                    req_resp;
   logic [3:0]                    beats_left; // zero on the last beat
   logic [axi_mem_pkg::idx_w-1:0] idx;
   logic                          req_ok;
   logic                          ar_fire;
   logic                          r_fire;

   assign ar_fire = ar_valid && ar_ready;
   assign r_fire  = r_valid && r_ready;
   assign req_ok  = (req_resp == axi_mem_pkg::resp_okay);

   // failed requests never touch the banks
   assign rd_en    = (state == st_issue) && req_ok;
   assign rd_index = idx;

   always_ff @(posedge clk or negedge resetn) begin
      if (!resetn) begin
         state    <= st_addr;
         ar_ready <= 1'b0;
         r_valid  <= 1'b0;
      end else begin
         case (state)
            st_addr: begin
               ar_ready <= 1'b1;
               if (ar_fire) begin
                  ar_ready <= 1'b0;
                  state    <= st_issue;
               end
            end
            st_issue: state <= st_wait;
            st_wait: begin
               r_valid <= 1'b1;
               state   <= st_present;
            end
            st_present: begin
               if (r_fire) begin
                  r_valid <= 1'b0;
                  if (r.last) begin
                     ar_ready <= 1'b1;
                     state    <= st_addr;
                  end else begin
                     state <= st_issue;
                  end
               end
            end
            default: state <= st_addr;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (ar_fire) begin
         req_id     <= ar.id;
         req_len    <= ar.len;
         req_burst  <= ar.burst;
         req_resp   <= axi_mem_pkg::check_req(ar);
         beats_left <= ar.len;
         idx        <= ar.addr[2 +: axi_mem_pkg::idx_w];
      end
      if (state == st_issue) begin
         idx <= axi_mem_pkg::next_index(idx, req_len, req_burst);
      end
      if (state == st_wait) begin
         r.id   <= req_id;
         r.data <= req_ok ? rd_word : '0;
         r.resp <= req_resp;
         r.last <= (beats_left == 4'd0);
      end
      if (r_fire) begin
         beats_left <= beats_left - 1'b1;
      end
   end

   a_r_stable: assert property (@(posedge clk) disable iff (!resetn)
      r_valid && !r_ready |=> r_valid && $stable(r))
      else $error("r beat changed while stalled");

endmodule

//--- axi_mem_slave.sv
`timescale 1ns/1ps

// 128 byte memory slave, four byte lanes of 32 words
module axi_mem_slave (
   input  logic                   clk,
   input  logic                   resetn,
   input  logic                   aw_valid,
   output logic                   aw_ready,
   input  axi_mem_pkg::addr_req_t aw,
   input  logic                   w_valid,
   output logic                   w_ready,
   input  axi_mem_pkg::w_beat_t   w,
   output logic                   b_valid,
   input  logic                   b_ready,
   output axi_mem_pkg::b_resp_t   b,
   input  logic                   ar_valid,
   output logic                   ar_ready,
   input  axi_mem_pkg::addr_req_t ar,
   output logic                   r_valid,
   input  logic                   r_ready,
   output axi_mem_pkg::r_beat_t   r
);

   logic [axi_mem_pkg::data_bytes-1:0]   lane_we;
   logic [axi_mem_pkg::idx_w-1:0]        wr_index;
   logic [8*axi_mem_pkg::data_bytes-1:0] wr_data;
   logic                                 rd_en;
   logic [axi_mem_pkg::idx_w-1:0]        rd_index;
   wire  [8*axi_mem_pkg::data_bytes-1:0] rd_word; // built lane by lane

   axi_write_ctrl u_wr (
      .clk      (clk),
      .resetn   (resetn),
      .aw_valid (aw_valid),
      .aw       (aw),
      .aw_ready (aw_ready),
      .w_valid  (w_valid),
      .w        (w),
      .w_ready  (w_ready),
      .b_ready  (b_ready),
      .b_valid  (b_valid),
      .b        (b),
      .lane_we  (lane_we),
      .wr_index (wr_index),
      .wr_data  (wr_data)
   );

   axi_read_ctrl u_rd (
      .clk      (clk),
      .resetn   (resetn),
      .ar_valid (ar_valid),
      .ar       (ar),
      .ar_ready (ar_ready),
      .r_ready  (r_ready),
      .r_valid  (r_valid),
      .r        (r),
      .rd_en    (rd_en),
      .rd_index (rd_index),
      .rd_word  (rd_word)
   );

   for (genvar g = 0; g < axi_mem_pkg::data_bytes; g++) begin : g_lane
      wire [7:0] wr_byte;
      wire [7:0] rd_byte;

      assign wr_byte            = wr_data[8*g +: 8];
      assign rd_word[8*g +: 8]  = rd_byte; // lane 0 is the low byte

      byte_lane_bank u_bank (
         .clk      (clk),
         .wr_en    (lane_we[g]),
         .wr_index (wr_index),
         .wr_byte  (wr_byte),
         .rd_en    (rd_en),
         .rd_index (rd_index),
         .rd_byte  (rd_byte)
      );
   end

endmodule

//--- tb_axi_mem_slave.sv
`timescale 1ns/1ps

module tb_axi_mem_slave;

   localparam int timeout_cycles = 200;

   logic                   clk;
   logic                   resetn;
   logic                   aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
   logic                   ar_valid, ar_ready, r_valid, r_ready;
   axi_mem_pkg::addr_req_t aw, ar;
   axi_mem_pkg::w_beat_t   w;
   axi_mem_pkg::b_resp_t   b;
   axi_mem_pkg::r_beat_t   r;
   logic [7:0]             model [128];
   bit                     written [128]; // bytes the model knows
   int                     errors;
   int                     timeouts;

   axi_mem_slave DUT (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   function automatic logic level(input int sel);
      case (sel)
         0:       return aw_ready;
         1:       return w_ready;
         default: return ar_ready;
      endcase
   endfunction

   // samples a ready output on falling edges
   task automatic wait_high(input int sel, input string what);
      int n;
      for (n = 0; n < timeout_cycles; n++) begin
         @(negedge clk);
         if (level(sel)) break;
      end
      if (n == timeout_cycles) begin
         $display("timeout while waiting for %s to go high", what);
         timeouts++;
      end
   endtask

   task automatic handshake(input int sel, input string what);
      wait_high(sel, what);
      @(posedge clk); // transfer edge
   endtask

   // takes one b or r beat while toggling ready at random
   task automatic collect(input bit is_r, output logic [38:0] beat);
      logic [38:0] held;
      bit          stalled;
      int          n;
      stalled = 1'b0;
      held    = '0;
      for (n = 0; n < timeout_cycles; n++) begin
         @(negedge clk);
         if (stalled) begin
            check("r_valid while stalled", r_valid, 1'b1);
            check("r while stalled", r, held);
         end
         if (is_r ? (r_valid && r_ready) : (b_valid && b_ready)) break;
         stalled = is_r && r_valid;
         held    = r;
         @(posedge clk);
         if (is_r) r_ready <= 1'($urandom);
         else b_ready <= 1'($urandom);
      end
      if (n == timeout_cycles) begin
         $display("timeout while waiting for a %s beat", is_r ? "read data" : "write response");
         timeouts++;
      end
      beat = is_r ? r : 39'(b);
      @(posedge clk);
      if (is_r) r_ready <= 1'b0;
      else b_ready <= 1'b0;
   endtask

   // word touched by a given beat of a burst
   function automatic int word_at(input axi_mem_pkg::addr_req_t req, input int beat);
      int start;
      int n;
      start = int'(req.addr[6:2]);
      n     = int'(req.len) + 1;
      if (req.burst == axi_mem_pkg::burst_fixed) return start;
      if (req.burst == axi_mem_pkg::burst_wrap) return start - start % n + (start % n + beat) % n;
      return (start + beat) % 32;
   endfunction

   function automatic axi_mem_pkg::addr_req_t make_req(input logic [3:0] id,
         input logic [31:0] addr, input logic [3:0] len, input logic [2:0] size,
         input logic [1:0] burst);
      return '{id, addr, len, size, burst};
   endfunction

   task automatic write_burst(input axi_mem_pkg::addr_req_t req, input logic [1:0] exp_resp);
      logic [31:0]          data;
      logic [3:0]           strb;
      logic [38:0]          raw;
      axi_mem_pkg::b_resp_t bb;
      int                   wi;
      @(posedge clk);
      aw_valid <= 1'b1;
      aw       <= req;
      handshake(0, "aw_ready");
      aw_valid <= 1'b0;
      for (int i = 0; i <= int'(req.len); i++) begin
         data = $urandom;
         strb = 4'($urandom);
         w_valid <= 1'b1;
         w       <= '{data, strb, i == int'(req.len)};
         handshake(1, "w_ready");
         wi = word_at(req, i);
         for (int k = 0; k < 4; k++) begin
            if (exp_resp == axi_mem_pkg::resp_okay && strb[k]) begin
               model[wi*4+k]   = data[8*k +: 8];
               written[wi*4+k] = 1'b1;
            end
         end
      end
      w_valid <= 1'b0;
      collect(1'b0, raw);
      bb = raw[5:0];
      check("bid", bb.id, req.id);
      check("bresp", bb.resp, exp_resp);
   endtask

   task automatic read_burst(input axi_mem_pkg::addr_req_t req, input logic [1:0] exp_resp);
      logic [38:0]          raw;
      axi_mem_pkg::r_beat_t rb;
      int                   wi;
      @(posedge clk);
      ar_valid <= 1'b1;
      ar       <= req;
      handshake(2, "ar_ready");
      ar_valid <= 1'b0;
      for (int i = 0; i <= int'(req.len); i++) begin
         collect(1'b1, raw);
         rb = raw;
         wi = word_at(req, i);
         check("rid", rb.id, req.id);
         check("rresp", rb.resp, exp_resp);
         check("rlast", rb.last, i == int'(req.len));
         if (exp_resp != axi_mem_pkg::resp_okay) check("rdata", rb.data, 32'h0);
         for (int k = 0; k < 4; k++) begin
            if (exp_resp == axi_mem_pkg::resp_okay && written[wi*4+k])
               check($sformatf("rdata byte %0d", wi*4+k), rb.data[8*k +: 8], model[wi*4+k]);
         end
      end
      @(negedge clk);
      check("r_valid after last", r_valid, 1'b0);
      check("ar_ready after last", ar_ready, 1'b1); // no extra beat pending
   endtask

   initial begin
      axi_mem_pkg::addr_req_t req;
      int                     base;
      void'($urandom(95137));
      resetn   = 1'b0;
      aw_valid = 1'b0;
      aw       = '0;
      w_valid  = 1'b0;
      w        = '0;
      b_ready  = 1'b0;
      ar_valid = 1'b0;
      ar       = '0;
      r_ready  = 1'b0;
      errors   = 0;
      timeouts = 0;
      repeat (4) @(posedge clk);
      resetn <= 1'b1;
      @(negedge clk);
      check("b_valid", b_valid, 1'b0);
      check("r_valid", r_valid, 1'b0);
      wait_high(0, "aw_ready");
      wait_high(2, "ar_ready");
      for (int t = 0; t < 12; t++) begin
         req = make_req(4'($urandom), 32'($urandom % 128), 4'($urandom),
                        axi_mem_pkg::full_size, axi_mem_pkg::burst_incr);
         write_burst(req, axi_mem_pkg::resp_okay);
         req.id = ~req.id;
         read_burst(req, axi_mem_pkg::resp_okay);
      end
      // fixed bursts merge into one word
      for (int t = 0; t < 4; t++) begin
         req = make_req(4'($urandom), 32'($urandom % 128), 4'($urandom % 15 + 1),
                        axi_mem_pkg::full_size, axi_mem_pkg::burst_fixed);
         write_burst(req, axi_mem_pkg::resp_okay);
         req.len = 4'd0;
         read_burst(req, axi_mem_pkg::resp_okay);
      end
      for (int k = 1; k <= 4; k++) begin
         base = int'($urandom % (32 >> k)) << k;
         req  = make_req(4'($urandom), 32'((base + 1 + int'($urandom % ((1 << k) - 1))) * 4),
                         4'((1 << k) - 1), axi_mem_pkg::full_size, axi_mem_pkg::burst_wrap);
         write_burst(req, axi_mem_pkg::resp_okay);
         read_burst(req, axi_mem_pkg::resp_okay);
         req.addr  = 32'(base * 4);   // linear pass over the window
         req.burst = axi_mem_pkg::burst_incr;
         read_burst(req, axi_mem_pkg::resp_okay);
      end
      // narrow size, reserved burst, wrap of 3, out of range
      write_burst(make_req(4'h3, 32'h10, 4'd3, 3'd1, 2'd1), axi_mem_pkg::resp_slverr);
      read_burst(make_req(4'h3, 32'h10, 4'd3, 3'd1, 2'd1), axi_mem_pkg::resp_slverr);
      write_burst(make_req(4'h4, 32'h20, 4'd2, 3'd2, 2'd3), axi_mem_pkg::resp_slverr);
      read_burst(make_req(4'h4, 32'h20, 4'd2, 3'd2, 2'd3), axi_mem_pkg::resp_slverr);
      write_burst(make_req(4'h5, 32'h30, 4'd2, 3'd2, 2'd2), axi_mem_pkg::resp_slverr);
      read_burst(make_req(4'h5, 32'h30, 4'd2, 3'd2, 2'd2), axi_mem_pkg::resp_slverr);
      write_burst(make_req(4'h6, 32'h80, 4'd1, 3'd2, 2'd1), axi_mem_pkg::resp_decerr);
      read_burst(make_req(4'h6, 32'hfc, 4'd1, 3'd2, 2'd1), axi_mem_pkg::resp_decerr);
      // whole memory must still match the model
      read_burst(make_req(4'h7, 32'h00, 4'd15, 3'd2, 2'd1), axi_mem_pkg::resp_okay);
      read_burst(make_req(4'h8, 32'h40, 4'd15, 3'd2, 2'd1), axi_mem_pkg::resp_okay);
      $display("errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

//--- compile.f
axi_mem_pkg.sv
byte_lane_bank.sv
axi_write_ctrl.sv
axi_read_ctrl.sv
axi_mem_slave.sv
tb_axi_mem_slave.sv

//--- Makefile
sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -f compile.f --top-module tb_axi_mem_slave
	./obj_dir/Vtb_axi_mem_slave | tee sim.log
	@if grep -q "Result: FAILED" sim.log || ! grep -q "Result: PASSED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
